// File: hw/tinyrv_pkg.sv
/*
 tinyrv shared types
 data, address and register index vectors, ALU and branch encodings,
 and the packets passed between fetch, decode, execute and the register file
 */
`default_nettype none

package tinyrv_pkg;

    typedef logic [31:0] word_t;      // register and memory data
    typedef logic [31:0] addr_t;      // byte address
    typedef logic [31:0] inst_t;      // raw instruction
    typedef logic [4:0]  reg_addr_t;  // x0..x31

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASSB  // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_JAL,
        BR_JALR
    } br_cond_e;

    typedef enum logic {
        EX_RUN,  // alu, branch or bubble
        EX_MEM   // load/store waiting for ready
    } ex_state_e;

    typedef struct packed {
        logic  valid;
        inst_t inst;
        addr_t pc;
    } fetch_pkt_t;

    // operands already resolved, rs2 kept for compare and store data
    typedef struct packed {
        logic      valid;
        addr_t     pc;
        word_t     op_a;
        word_t     op_b;
        word_t     rs2_data;
        word_t     imm;
        alu_op_e   alu_op;
        br_cond_e  br_cond;
        logic      is_load;
        logic      is_store;
        logic      rd_we;
        reg_addr_t rd;
    } dec_pkt_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_pkt_t;

    typedef struct packed {
        logic  jump;
        addr_t target;
    } redirect_t;

endpackage

`default_nettype wire

// File: hw/pc_reg.sv
/*
 program counter
 steps by four on each accepted fetch, loads the target on a jump
 */
`default_nettype none

module pc_reg #(
    parameter tinyrv_pkg::addr_t ResetPc = 32'h0
) (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  wire                   fetch_done_i,  // instruction captured by if_id
    input  wire tinyrv_pkg::redirect_t redirect_i,
    output tinyrv_pkg::addr_t     pc_o
);

    tinyrv_pkg::addr_t pc_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= ResetPc;
        end else if (redirect_i.jump) begin
            pc_q <= redirect_i.target;  // jump wins over a completed fetch
        end else if (fetch_done_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: hw/if_id.sv
/*
 fetch stage
 issues instruction requests, holds the fetched word with its PC for decode
 and throws away responses that a jump has made stale
 */
`default_nettype none

module if_id (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire tinyrv_pkg::addr_t     pc_i,
    input  wire                        instr_ready_i,
    input  wire tinyrv_pkg::inst_t     inst_i,
    input  wire                        stall_i,  // execute stage busy
    input  wire tinyrv_pkg::redirect_t redirect_i,
    output logic                       instr_req_o,
    output logic                       fetch_done_o,
    output tinyrv_pkg::fetch_pkt_t     fetch_o
);

    tinyrv_pkg::fetch_pkt_t fetch_q;
    logic pend_q;  // request waiting for ready
    logic drop_q;  // pending response belongs to the old path
    logic take;

    // ask whenever the held packet leaves at the next edge or is empty
    assign instr_req_o = pend_q | !fetch_q.valid | !stall_i;

    assign take = instr_req_o & instr_ready_i & !drop_q & !redirect_i.jump;
    assign fetch_done_o = take;
    assign fetch_o = fetch_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pend_q        <= 1'b0;
            drop_q        <= 1'b0;
            fetch_q.valid <= 1'b0;
        end else begin
            pend_q <= instr_req_o & !instr_ready_i;

            if (redirect_i.jump) begin
                drop_q <= instr_req_o & !instr_ready_i;
            end else if (instr_ready_i) begin
                drop_q <= 1'b0;  // stale word has arrived
            end

            if (redirect_i.jump) begin
                fetch_q.valid <= 1'b0;  // flush younger instruction
            end else if (take) begin
                fetch_q.valid <= 1'b1;
                fetch_q.inst  <= inst_i;
                fetch_q.pc    <= pc_i;
            end else if (!stall_i) begin
                fetch_q.valid <= 1'b0;  // consumed by execute
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/id.sv
/*
 instruction decoder
 pure combinational: reads both source registers, builds the immediate
 and the operand pair, and turns anything unsupported into a bubble
 */
`default_nettype none

module id (
    input  wire tinyrv_pkg::fetch_pkt_t fetch_i,
    input  wire tinyrv_pkg::word_t      rs1_data_i,
    input  wire tinyrv_pkg::word_t      rs2_data_i,
    input  wire tinyrv_pkg::redirect_t  redirect_i,
    output tinyrv_pkg::reg_addr_t       rs1_addr_o,
    output tinyrv_pkg::reg_addr_t       rs2_addr_o,
    output tinyrv_pkg::dec_pkt_t        dec_o
);

    localparam logic [6:0] OpcOp     = 7'b0110011;
    localparam logic [6:0] OpcOpImm  = 7'b0010011;
    localparam logic [6:0] OpcLui    = 7'b0110111;
    localparam logic [6:0] OpcAuipc  = 7'b0010111;
    localparam logic [6:0] OpcJal    = 7'b1101111;
    localparam logic [6:0] OpcJalr   = 7'b1100111;
    localparam logic [6:0] OpcBranch = 7'b1100011;
    localparam logic [6:0] OpcLoad   = 7'b0000011;
    localparam logic [6:0] OpcStore  = 7'b0100011;

    tinyrv_pkg::inst_t inst;
    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    tinyrv_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
    logic legal;

    // funct3 to alu op, alt picks sub/sra
    function automatic tinyrv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_sel = alt ? tinyrv_pkg::ALU_SUB : tinyrv_pkg::ALU_ADD;
            3'b001:  alu_sel = tinyrv_pkg::ALU_SLL;
            3'b010:  alu_sel = tinyrv_pkg::ALU_SLT;
            3'b011:  alu_sel = tinyrv_pkg::ALU_SLTU;
            3'b100:  alu_sel = tinyrv_pkg::ALU_XOR;
            3'b101:  alu_sel = alt ? tinyrv_pkg::ALU_SRA : tinyrv_pkg::ALU_SRL;
            3'b110:  alu_sel = tinyrv_pkg::ALU_OR;
            default: alu_sel = tinyrv_pkg::ALU_AND;
        endcase
    endfunction

    assign inst   = fetch_i.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec_o          = '0;
        legal          = 1'b1;
        dec_o.pc       = fetch_i.pc;
        dec_o.op_a     = rs1_data_i;
        dec_o.op_b     = rs2_data_i;
        dec_o.rs2_data = rs2_data_i;  // branch compare and store data
        dec_o.imm      = imm_i;
        dec_o.rd       = inst[11:7];
        dec_o.alu_op   = tinyrv_pkg::ALU_ADD;
        dec_o.br_cond  = tinyrv_pkg::BR_NONE;

        case (opcode)
            OpcOp: begin
                legal = (funct7 == 7'b0) |
                        (funct7 == 7'b0100000 & (funct3 == 3'b000 | funct3 == 3'b101));
                dec_o.alu_op = alu_sel(funct3, funct7[5]);
                dec_o.rd_we  = 1'b1;
            end
            OpcOpImm: begin
                // shifts carry funct7 in the immediate field
                legal = (funct3[1:0] != 2'b01) | (funct7 == 7'b0) |
                        (funct3 == 3'b101 & funct7 == 7'b0100000);
                dec_o.alu_op = alu_sel(funct3, funct3 == 3'b101 & funct7[5]);
                dec_o.op_b   = imm_i;
                dec_o.rd_we  = 1'b1;
            end
            OpcLui: begin
                dec_o.alu_op = tinyrv_pkg::ALU_PASSB;
                dec_o.op_b   = imm_u;
                dec_o.rd_we  = 1'b1;
            end
            OpcAuipc: begin
                dec_o.op_a  = fetch_i.pc;
                dec_o.op_b  = imm_u;
                dec_o.rd_we = 1'b1;
            end
            OpcJal: begin
                dec_o.op_a    = fetch_i.pc;
                dec_o.op_b    = imm_j;
                dec_o.imm     = imm_j;
                dec_o.br_cond = tinyrv_pkg::BR_JAL;
                dec_o.rd_we   = 1'b1;
            end
            OpcJalr: begin
                legal         = (funct3 == 3'b000);
                dec_o.op_b    = imm_i;  // rs1 + imm
                dec_o.br_cond = tinyrv_pkg::BR_JALR;
                dec_o.rd_we   = 1'b1;
            end
            OpcBranch: begin
                dec_o.imm    = imm_b;
                dec_o.alu_op = tinyrv_pkg::ALU_SUB;
                case (funct3)
                    3'b000:  dec_o.br_cond = tinyrv_pkg::BR_EQ;
                    3'b001:  dec_o.br_cond = tinyrv_pkg::BR_NE;
                    3'b100:  dec_o.br_cond = tinyrv_pkg::BR_LT;
                    3'b101:  dec_o.br_cond = tinyrv_pkg::BR_GE;
                    default: legal = 1'b0;  // no unsigned branches
                endcase
            end
            OpcLoad: begin
                legal         = (funct3 == 3'b010);  // lw only
                dec_o.op_b    = imm_i;
                dec_o.is_load = 1'b1;
                dec_o.rd_we   = 1'b1;
            end
            OpcStore: begin
                legal          = (funct3 == 3'b010);  // sw only
                dec_o.op_b     = imm_s;
                dec_o.imm      = imm_s;
                dec_o.is_store = 1'b1;
            end
            default: legal = 1'b0;
        endcase

        // bubble on flush or unknown encoding
        dec_o.valid = fetch_i.valid & legal & !redirect_i.jump;
    end

endmodule

`default_nettype wire

// File: hw/regs.sv
/*
 integer register file
 x1..x31 with two read ports, x0 hardwired to zero,
 a write in flight is forwarded to a read of the same register
 */
`default_nettype none

module regs (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire tinyrv_pkg::wb_pkt_t   wb_i,
    input  wire tinyrv_pkg::reg_addr_t raddr1_i,
    input  wire tinyrv_pkg::reg_addr_t raddr2_i,
    output tinyrv_pkg::word_t          rdata1_o,
    output tinyrv_pkg::word_t          rdata2_o
);

    tinyrv_pkg::word_t regs_q [31:1];

    // one read port: zero, bypass, or stored value
    function automatic tinyrv_pkg::word_t rd_port(input tinyrv_pkg::reg_addr_t addr);
        if (addr == '0) begin
            rd_port = '0;
        end else if (wb_i.we && wb_i.waddr == addr) begin
            rd_port = wb_i.wdata;
        end else begin
            rd_port = regs_q[addr];
        end
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.we && wb_i.waddr != '0) begin  // x0 writes dropped
            regs_q[wb_i.waddr] <= wb_i.wdata;
        end
    end

    always_comb begin
        rdata1_o = rd_port(raddr1_i);
        rdata2_o = rd_port(raddr2_i);
    end

endmodule

`default_nettype wire

// File: hw/ex.sv
/*
 execute stage
 input register, ALU, branch resolution and writeback,
 loads and stores wait in EX_MEM until the data port answers
 */
`default_nettype none

module ex (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire tinyrv_pkg::dec_pkt_t  dec_i,
    input  wire tinyrv_pkg::word_t     mem_rdata_i,
    input  wire                        mem_ready_i,
    output logic                       busy_o,
    output tinyrv_pkg::redirect_t      redirect_o,
    output tinyrv_pkg::wb_pkt_t        wb_o,
    output logic                       mem_req_o,
    output logic                       mem_we_o,
    output tinyrv_pkg::addr_t          mem_addr_o,
    output tinyrv_pkg::word_t          mem_wdata_o
);

    tinyrv_pkg::ex_state_e state_q;
    tinyrv_pkg::dec_pkt_t  ex_q;
    tinyrv_pkg::word_t     alu_res;
    tinyrv_pkg::word_t     link;
    logic [4:0] shamt;
    logic in_mem;
    logic taken;
    logic is_jump;

    assign in_mem = (state_q == tinyrv_pkg::EX_MEM);
    assign busy_o = in_mem & !mem_ready_i;  // free again in the ready cycle

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= tinyrv_pkg::EX_RUN;
            ex_q.valid <= 1'b0;
        end else if (!busy_o) begin
            ex_q <= dec_i;
            if (dec_i.valid && (dec_i.is_load || dec_i.is_store)) begin
                state_q <= tinyrv_pkg::EX_MEM;
            end else begin
                state_q <= tinyrv_pkg::EX_RUN;
            end
        end
    end

    assign shamt = ex_q.op_b[4:0];

    always_comb begin
        case (ex_q.alu_op)
            tinyrv_pkg::ALU_SUB:   alu_res = ex_q.op_a - ex_q.op_b;
            tinyrv_pkg::ALU_AND:   alu_res = ex_q.op_a & ex_q.op_b;
            tinyrv_pkg::ALU_OR:    alu_res = ex_q.op_a | ex_q.op_b;
            tinyrv_pkg::ALU_XOR:   alu_res = ex_q.op_a ^ ex_q.op_b;
            tinyrv_pkg::ALU_SLL:   alu_res = ex_q.op_a << shamt;
            tinyrv_pkg::ALU_SRL:   alu_res = ex_q.op_a >> shamt;
            tinyrv_pkg::ALU_SRA:   alu_res = $signed(ex_q.op_a) >>> shamt;
            tinyrv_pkg::ALU_SLT:   alu_res = {31'b0, $signed(ex_q.op_a) < $signed(ex_q.op_b)};
            tinyrv_pkg::ALU_SLTU:  alu_res = {31'b0, ex_q.op_a < ex_q.op_b};
            tinyrv_pkg::ALU_PASSB: alu_res = ex_q.op_b;
            default:               alu_res = ex_q.op_a + ex_q.op_b;  // also mem address
        endcase
    end

    // compare rs1 (op_a) against rs2
    always_comb begin
        case (ex_q.br_cond)
            tinyrv_pkg::BR_EQ:   taken = (ex_q.op_a == ex_q.rs2_data);
            tinyrv_pkg::BR_NE:   taken = (ex_q.op_a != ex_q.rs2_data);
            tinyrv_pkg::BR_LT:   taken = $signed(ex_q.op_a) < $signed(ex_q.rs2_data);
            tinyrv_pkg::BR_GE:   taken = $signed(ex_q.op_a) >= $signed(ex_q.rs2_data);
            tinyrv_pkg::BR_JAL,
            tinyrv_pkg::BR_JALR: taken = 1'b1;
            default:             taken = 1'b0;
        endcase
    end

    assign is_jump = (ex_q.br_cond == tinyrv_pkg::BR_JAL) |
                     (ex_q.br_cond == tinyrv_pkg::BR_JALR);
    assign link = ex_q.pc + 32'd4;

    assign redirect_o.jump   = ex_q.valid & taken;
    assign redirect_o.target = (ex_q.br_cond == tinyrv_pkg::BR_JALR) ?
                               {alu_res[31:1], 1'b0} : ex_q.pc + ex_q.imm;

    // loads write in the ready cycle, everything else right away
    assign wb_o.we    = ex_q.valid & ex_q.rd_we & (!ex_q.is_load | (in_mem & mem_ready_i));
    assign wb_o.waddr = ex_q.rd;
    assign wb_o.wdata = ex_q.is_load ? mem_rdata_i : (is_jump ? link : alu_res);

    // held stable by the input register while busy
    assign mem_req_o   = in_mem;
    assign mem_we_o    = ex_q.is_store;
    assign mem_addr_o  = alu_res;
    assign mem_wdata_o = ex_q.rs2_data;

endmodule

`default_nettype wire

// File: hw/tinyrv_core.sv
/*
 tinyrv core top
 RV32I subset pipeline: pc, fetch, decode, execute and register file
 joined to an instruction port and a data port
 */
`default_nettype none

module tinyrv_core #(
    parameter tinyrv_pkg::addr_t ResetPc = 32'h0
) (
    input  wire                    clk_i,
    input  wire                    rst_n_i,

    output logic                   rib_pc_req_o,   // instruction fetch
    output tinyrv_pkg::addr_t      rib_pc_addr_o,
    input  wire tinyrv_pkg::inst_t rib_pc_data_i,
    input  wire                    rib_pc_ready_i,

    output logic                   rib_ex_req_o,   // load/store
    output logic                   rib_ex_we_o,
    output tinyrv_pkg::addr_t      rib_ex_addr_o,
    output tinyrv_pkg::word_t      rib_ex_data_o,
    input  wire tinyrv_pkg::word_t rib_ex_data_i,
    input  wire                    rib_ex_ready_i
);

    tinyrv_pkg::fetch_pkt_t fetch;
    tinyrv_pkg::dec_pkt_t   dec;
    tinyrv_pkg::wb_pkt_t    wb;
    tinyrv_pkg::redirect_t  redirect;  // from execute to pc and fetch
    tinyrv_pkg::reg_addr_t  rs1_addr, rs2_addr;
    tinyrv_pkg::word_t      rs1_data, rs2_data;
    logic fetch_done;
    logic ex_busy;

    pc_reg #(
        .ResetPc(ResetPc)
    ) u_pc_reg (
        .clk_i,
        .rst_n_i,
        .fetch_done_i(fetch_done),
        .redirect_i  (redirect),
        .pc_o        (rib_pc_addr_o)
    );

    if_id u_if_id (
        .clk_i,
        .rst_n_i,
        .pc_i         (rib_pc_addr_o),
        .instr_ready_i(rib_pc_ready_i),
        .inst_i       (rib_pc_data_i),
        .stall_i      (ex_busy),
        .redirect_i   (redirect),
        .instr_req_o  (rib_pc_req_o),
        .fetch_done_o (fetch_done),
        .fetch_o      (fetch)
    );

    id u_id (
        .fetch_i   (fetch),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .redirect_i(redirect),
        .rs1_addr_o(rs1_addr),
        .rs2_addr_o(rs2_addr),
        .dec_o     (dec)
    );

    regs u_regs (
        .clk_i,
        .rst_n_i,
        .wb_i    (wb),
        .raddr1_i(rs1_addr),
        .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data),
        .rdata2_o(rs2_data)
    );

    ex u_ex (
        .clk_i,
        .rst_n_i,
        .dec_i      (dec),
        .mem_rdata_i(rib_ex_data_i),
        .mem_ready_i(rib_ex_ready_i),
        .busy_o     (ex_busy),
        .redirect_o (redirect),
        .wb_o       (wb),
        .mem_req_o  (rib_ex_req_o),
        .mem_we_o   (rib_ex_we_o),
        .mem_addr_o (rib_ex_addr_o),
        .mem_wdata_o(rib_ex_data_o)
    );

endmodule

`default_nettype wire

// File: dv/tb_core_model.svh
/*
 tinyrv reference model
 random forward-only program generator and an RV32I subset
 instruction-set model that lists executed PCs and stores
 */
`ifndef TB_CORE_MODEL_SVH
`define TB_CORE_MODEL_SVH

localparam logic [6:0] OpcOp     = 7'b0110011;
localparam logic [6:0] OpcOpImm  = 7'b0010011;
localparam logic [6:0] OpcLui    = 7'b0110111;
localparam logic [6:0] OpcAuipc  = 7'b0010111;
localparam logic [6:0] OpcJal    = 7'b1101111;
localparam logic [6:0] OpcJalr   = 7'b1100111;
localparam logic [6:0] OpcBranch = 7'b1100011;
localparam logic [6:0] OpcLoad   = 7'b0000011;
localparam logic [6:0] OpcStore  = 7'b0100011;

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
endfunction

// memory fill, every address bit matters
function automatic tinyrv_pkg::word_t data_init(input tinyrv_pkg::addr_t addr);
    return (addr * 32'h9e3779b1) ^ 32'h0f0f1234;
endfunction

function automatic tinyrv_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic tinyrv_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic tinyrv_pkg::inst_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OpcStore};
endfunction

function automatic tinyrv_pkg::inst_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpcBranch};
endfunction

function automatic tinyrv_pkg::inst_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpcJal};
endfunction

function automatic tinyrv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                              input tinyrv_pkg::word_t a,
                                              input tinyrv_pkg::word_t b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// slot kinds: 0..8 single instructions, 10/11/9 = lui, addi, jalr triple
task automatic build_program();
    logic [31:0] s;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    int i, t, span, k;
    s = 32'hbf77;
    for (i = 0; i < ProgLen; i++) begin
        kinds[i] = 12;
    end
    i = 1;
    while (i < ProgLen - 1) begin
        s = xorshift(s);
        k = int'(s % 10);
        if (k == 9 && i + 2 < ProgLen - 1) begin
            kinds[i]     = 10;
            kinds[i + 1] = 11;
            kinds[i + 2] = 9;
            i += 3;
        end else begin
            kinds[i] = (k == 9) ? 2 : k;
            i++;
        end
    end
    prog[0]           = {20'h1, 5'd31, OpcLui};  // x31 = data region base
    prog[ProgLen - 1] = enc_j(21'd0, 5'd0);      // final self-loop
    for (i = 1; i < ProgLen - 1; i++) begin
        s    = xorshift(s);
        rd   = 5'(s % 8);  // few registers, many dependencies
        rs1  = 5'((s >> 4) % 8);
        rs2  = 5'((s >> 8) % 8);
        f3   = s[14:12];
        imm  = s[27:16];
        span = (ProgLen - 1 - i < 8) ? ProgLen - 1 - i : 8;
        t    = i + 1 + int'(s[31:29]) % span;
        // never land inside a jalr triple past its lui
        if (kinds[t] == 11) begin
            t -= 1;
        end else if (kinds[t] == 9) begin
            t -= 2;
        end
        case (kinds[i])
            0, 1: prog[i] = enc_r(((f3 == 3'd0 || f3 == 3'd5) && s[15]) ? 7'h20 : 7'h00,
                                  rs2, rs1, f3, rd, OpcOp);
            2, 3: begin
                if (f3 == 3'd1) begin
                    imm = {7'h00, imm[4:0]};
                end else if (f3 == 3'd5) begin
                    imm = {s[15] ? 7'h20 : 7'h00, imm[4:0]};
                end
                prog[i] = enc_i(imm, rs1, f3, rd, OpcOpImm);
            end
            4: prog[i] = {s[31:12], rd, s[15] ? OpcLui : OpcAuipc};
            5: prog[i] = enc_s({6'b0, s[19:16], 2'b0}, rs2, 5'd31);
            6: prog[i] = enc_i({6'b0, s[19:16], 2'b0}, 5'd31, 3'b010, rd, OpcLoad);
            7: prog[i] = enc_b(13'((t - i) * 4), rs2, rs1, {s[15], 1'b0, s[16]});
            8: prog[i] = enc_j(21'((t - i) * 4), rd);
            9: begin
                prog[i - 2] = {20'h0, 5'd30, OpcLui};
                prog[i - 1] = enc_i(12'(t * 4), 5'd30, 3'b000, 5'd30, OpcOpImm);
                prog[i]     = enc_i(12'h0, 5'd30, 3'b000, rd, OpcJalr);
            end
            default: ;
        endcase
    end
endtask

task automatic run_model();
    tinyrv_pkg::word_t x [32];
    tinyrv_pkg::word_t mem [DataWords];
    tinyrv_pkg::addr_t pc, nxt, ea;
    tinyrv_pkg::inst_t ins;
    tinyrv_pkg::word_t a, b, r, imm_i, imm_s, imm_b, imm_j;
    logic wr, tk;
    int n;
    for (n = 0; n < 32; n++) begin
        x[n] = '0;
    end
    for (n = 0; n < DataWords; n++) begin
        mem[n] = data_init(DataBase + 32'(n * 4));
    end
    pc = '0;
    for (n = 0; n < 4 * ProgLen; n++) begin
        ins = prog[int'(pc >> 2)];
        exp_pc.push_back(pc);
        if (ins == enc_j(21'd0, 5'd0)) begin
            break;
        end
        a     = x[ins[19:15]];
        b     = x[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt   = pc + 32'd4;
        wr    = 1'b1;
        r     = '0;
        case (ins[6:0])
            OpcOp:    r = alu_ref(ins[14:12], ins[30], a, b);
            OpcOpImm: r = alu_ref(ins[14:12], ins[14:12] == 3'b101 && ins[30], a, imm_i);
            OpcLui:   r = {ins[31:12], 12'b0};
            OpcAuipc: r = pc + {ins[31:12], 12'b0};
            OpcJal: begin
                r   = pc + 32'd4;
                nxt = pc + imm_j;
            end
            OpcJalr: begin
                r   = pc + 32'd4;
                nxt = (a + imm_i) & ~32'd1;
            end
            OpcBranch: begin
                wr = 1'b0;
                case (ins[14:12])
                    3'b000:  tk = (a == b);
                    3'b001:  tk = (a != b);
                    3'b100:  tk = $signed(a) < $signed(b);
                    default: tk = $signed(a) >= $signed(b);
                endcase
                if (tk) begin
                    nxt = pc + imm_b;
                end
            end
            OpcLoad: begin
                ea = a + imm_i;
                r  = mem[int'((ea - DataBase) >> 2)];
            end
            OpcStore: begin
                wr = 1'b0;
                ea = a + imm_s;
                exp_addr.push_back(ea);
                exp_data.push_back(b);
                mem[int'((ea - DataBase) >> 2)] = b;
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            x[ins[11:7]] = r;  // x0 stays zero
        end
        pc = nxt;
    end
endtask

`endif

// File: dv/tb_tinyrv_core.sv
/*
 tinyrv core testbench
 runs a random program against the ISA model, with random wait states on
 both memory ports, and checks executed PCs, store order and bus stability
 */
`default_nettype none

module tb_tinyrv_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ProgLen   = 200;
    localparam int ClkPeriod = 8;
    localparam int DataWords = 16;
    localparam int Watchdog  = ProgLen * 8 * 10 * ClkPeriod;  // in ns
    localparam tinyrv_pkg::addr_t DataBase = 32'h1000;

    logic clk;
    logic rst_n;
    logic pc_req, pc_ready;
    logic ex_req, ex_we, ex_ready;
    tinyrv_pkg::addr_t pc_addr, ex_addr;
    tinyrv_pkg::inst_t pc_data;
    tinyrv_pkg::word_t ex_wdata, ex_rdata;

    tinyrv_pkg::inst_t prog [ProgLen];
    int kinds [ProgLen];
    tinyrv_pkg::word_t dmem [DataWords];
    tinyrv_pkg::addr_t exp_addr [$];
    tinyrv_pkg::word_t exp_data [$];
    tinyrv_pkg::addr_t exp_pc [$];
    int errors = 0;
    int st_idx = 0;
    int pc_idx = 0;
    logic [31:0] pc_rng, ex_rng;  // one stream per responder
    int pc_wait, ex_wait;
    logic ex_seen;
    logic hold_we;
    tinyrv_pkg::addr_t hold_addr;
    tinyrv_pkg::word_t hold_data;

`include "tb_core_model.svh"

    tinyrv_core #(
        .ResetPc(32'h0)
    ) UUT (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .rib_pc_req_o  (pc_req),
        .rib_pc_addr_o (pc_addr),
        .rib_pc_data_i (pc_data),
        .rib_pc_ready_i(pc_ready),
        .rib_ex_req_o  (ex_req),
        .rib_ex_we_o   (ex_we),
        .rib_ex_addr_o (ex_addr),
        .rib_ex_data_o (ex_wdata),
        .rib_ex_data_i (ex_rdata),
        .rib_ex_ready_i(ex_ready)
    );

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // -1 when outside the data region
    function automatic int data_index(input tinyrv_pkg::addr_t addr);
        if (addr[1:0] != 2'b00 || addr < DataBase || addr >= DataBase + 4 * DataWords) begin
            return -1;
        end
        return int'((addr - DataBase) >> 2);
    endfunction

    function automatic tinyrv_pkg::inst_t fetch_word(input tinyrv_pkg::addr_t addr);
        if (addr[1:0] == 2'b00 && (addr >> 2) < ProgLen) begin
            return prog[int'(addr >> 2)];
        end
        return 32'h0000_0013;  // nop past the end
    endfunction

    task automatic record_store(input tinyrv_pkg::addr_t addr, input tinyrv_pkg::word_t data);
        int idx;
        idx = data_index(addr);
        if (idx < 0) begin
            errors++;
            $display("Store to %h falls outside the data region", addr);
        end else begin
            dmem[idx] = data;
        end
        if (st_idx < exp_addr.size()) begin
            check_eq(addr, exp_addr[st_idx], "store address");
            check_eq(data, exp_data[st_idx], "store data");
            st_idx++;
        end else begin
            errors++;
            $display("Store to %h came after the last expected store", addr);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // instruction memory with 0 to 3 wait states
    always @(posedge clk) begin
        if (!rst_n) begin
            pc_ready <= 1'b0;
        end else if (pc_ready) begin
            pc_ready <= 1'b0;
            pc_rng = xorshift(pc_rng);
            pc_wait = int'(pc_rng % 4);
        end else if (pc_req) begin
            if (pc_wait > 0) begin
                pc_wait--;
            end else begin
                pc_ready <= 1'b1;
                pc_data  <= fetch_word(pc_addr);
            end
        end
    end

    // data memory, also watches that a pending access holds still
    always @(posedge clk) begin
        int idx;
        if (rst_n && ex_req) begin
            if (!ex_seen) begin
                ex_seen   = 1'b1;
                hold_we   = ex_we;
                hold_addr = ex_addr;
                hold_data = ex_wdata;
            end else begin
                check_eq(32'(ex_we), 32'(hold_we), "held write enable");
                check_eq(ex_addr, hold_addr, "held data address");
                if (hold_we) begin
                    check_eq(ex_wdata, hold_data, "held store data");
                end
            end
        end
        if (!rst_n) begin
            ex_ready <= 1'b0;
        end else if (ex_ready) begin
            ex_ready <= 1'b0;
            ex_seen = 1'b0;
            ex_rng = xorshift(ex_rng);
            ex_wait = int'(ex_rng % 4);
            if (ex_req && ex_we) begin
                record_store(ex_addr, ex_wdata);
            end
        end else if (ex_req) begin
            if (ex_wait > 0) begin
                ex_wait--;
            end else begin
                ex_ready <= 1'b1;
                idx = data_index(ex_addr);
                if (!ex_we && idx < 0) begin
                    errors++;
                    $display("Load from %h falls outside the data region", ex_addr);
                end else if (!ex_we) begin
                    ex_rdata <= dmem[idx];
                end
            end
        end
    end

    // executed instruction leaves the execute stage
    always @(posedge clk) begin
        if (rst_n && UUT.u_ex.ex_q.valid && !UUT.u_ex.busy_o && pc_idx < exp_pc.size()) begin
            check_eq(UUT.u_ex.ex_q.pc, exp_pc[pc_idx], "executed pc");
            pc_idx++;
        end
    end

    initial begin
        rst_n    = 1'b0;
        pc_ready = 1'b0;
        pc_data  = '0;
        ex_ready = 1'b0;
        ex_rdata = '0;
        ex_seen  = 1'b0;
        pc_wait  = 0;
        ex_wait  = 0;
        pc_rng   = xorshift(32'hbf77);
        ex_rng   = xorshift(pc_rng);
        build_program();
        run_model();
        for (int n = 0; n < DataWords; n++) begin
            dmem[n] = data_init(DataBase + 32'(n * 4));
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_eq(32'(ex_req), 32'd0, "data request after reset");
        check_eq(32'(pc_req), 32'd1, "fetch request after reset");
        check_eq(pc_addr, 32'h0, "first fetch address");
        while (pc_idx < exp_pc.size() || st_idx < exp_addr.size()) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);  // catch any late extra store
        $display("%0d errors, %0d instructions and %0d stores checked",
                 errors, pc_idx, st_idx);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(Watchdog);
        $display("Watchdog expired: the core did not reach the final loop within %0d ns",
                 Watchdog);
        $display("%0d errors, %0d instructions and %0d stores checked",
                 errors, pc_idx, st_idx);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+dv
hw/tinyrv_pkg.sv
hw/pc_reg.sv
hw/if_id.sv
hw/id.sv
hw/regs.sv
hw/ex.sv
hw/tinyrv_core.sv
dv/tb_tinyrv_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the tinyrv testbench with Verilator
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_tinyrv_core -o sim_tinyrv \
    && ./obj_dir/sim_tinyrv > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL: no result in log"; exit 1; }
echo "PASS"
exit 0
